//--- common/prefetch_pkg.sv
// Address and instruction types, bus and fetch structs, FSM state types, fetch step
package prefetch_pkg;

  ////////////////////////////////
  // Basic word types
  ////////////////////////////////

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // One instruction word
  typedef logic [31:0] instr_t;

  // Address step between sequential fetches
  localparam int unsigned WORD_BYTES = 4;

  ////////////////////////////////
  // Bus structs
  ////////////////////////////////

  // Request phase toward memory
  typedef struct packed {
    logic  req;
    addr_t addr;
  } obi_req_t;

  // Grant plus response phase from memory
  typedef struct packed {
    logic   gnt;
    logic   rvalid;
    instr_t rdata;
  } obi_rsp_t;

  ////////////////////////////////
  // Fetch stage structs
  ////////////////////////////////

  // Redirect from the fetch stage
  typedef struct packed {
    logic  taken;
    addr_t target;
  } branch_t;

  // Instruction handed to the fetch stage
  typedef struct packed {
    logic   valid;
    instr_t instr;
  } fetch_t;

  // Controller FSM
  typedef enum logic {IDLE, BRANCH_WAIT} pf_state_e;

  // Bus adapter FSM
  typedef enum logic {TRANSPARENT, REGISTERED} adapter_state_e;

endpackage

//--- source/instr_obi_adapter.sv
// Bus adapter that forwards transactions and holds an ungranted request stable
module instr_obi_adapter
  import prefetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Transaction side
  input  logic     trans_valid_i,
  output logic     trans_ready_o,
  input  addr_t    trans_addr_i,
  output logic     resp_valid_o,
  output instr_t   resp_rdata_o,

  // Bus side
  output obi_req_t obi_req_o,
  input  obi_rsp_t obi_rsp_i
);

  adapter_state_e state_q;
  adapter_state_e next_state;

  // Captured address of a waiting request
  addr_t          addr_q;
  logic           capture;

  ////////////////////////////////
  // Request phase
  ////////////////////////////////

  always_comb begin
    next_state    = state_q;
    trans_ready_o = 1'b0;
    capture       = 1'b0;
    obi_req_o     = '0;
    case (state_q)
      TRANSPARENT: begin
        // Pass the request straight through
        trans_ready_o  = 1'b1;
        obi_req_o.req  = trans_valid_i;
        obi_req_o.addr = trans_addr_i;
        // No grant yet, freeze it for the next cycles
        if (trans_valid_i && !obi_rsp_i.gnt) begin
          capture    = 1'b1;
          next_state = REGISTERED;
        end
      end
      REGISTERED: begin
        // Controller address may move, the bus keeps the old one
        obi_req_o.req  = 1'b1;
        obi_req_o.addr = addr_q;
        if (obi_rsp_i.gnt) begin
          next_state = TRANSPARENT;
        end
      end
      default: begin
        next_state = TRANSPARENT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TRANSPARENT;
    end else begin
      state_q <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q <= trans_addr_i;
    end
  end

  ////////////////////////////////
  // Response phase
  ////////////////////////////////

  // Responses arrive in order and need no buffering here
  assign resp_valid_o = obi_rsp_i.rvalid;
  assign resp_rdata_o = obi_rsp_i.rdata;

endmodule

//--- prefetch/fetch_fifo.sv
// Circular instruction FIFO with push, pop, single-cycle flush and occupancy count
module fetch_fifo
  import prefetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4,
  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int unsigned CNT_W = PTR_W + 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic             flush_i,
  input  instr_t           wdata_i,
  output instr_t           rdata_o,
  output logic [CNT_W-1:0] cnt_o,
  output logic             empty_o
);

  // Storage
  instr_t           mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic             do_push;
  logic             do_pop;

  // Step a pointer with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////////////////
  // Control
  ////////////////////////////////

  // Flush wins over push and pop
  assign do_push = push_i && !flush_i && (cnt_q < FIFO_DEPTH);
  assign do_pop  = pop_i && !flush_i && (cnt_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Drop all entries at once
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Count unchanged on simultaneous push and pop
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////
  // Data path
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Head of queue
  assign rdata_o = mem_q[rd_ptr_q];
  assign cnt_o   = cnt_q;
  assign empty_o = (cnt_q == '0);

endmodule

//--- prefetch/prefetch_ctrl.sv
// Prefetch controller with request generation, branch FSM, outstanding and flush counters
module prefetch_ctrl
  import prefetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4,
  // Occupancy counters need one bit more than a pointer
  localparam int unsigned CNT_W = ((FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1) + 1
) (
  input  logic             clk,
  input  logic             rst_n,

  // Fetch stage side
  input  logic             req_i,
  input  branch_t          branch_i,
  input  logic             fetch_ready_i,
  output logic             fetch_valid_o,
  output logic             busy_o,

  // Transaction side toward the bus adapter
  output logic             trans_valid_o,
  input  logic             trans_ready_i,
  output addr_t            trans_addr_o,
  input  logic             resp_valid_i,

  // FIFO control
  output logic             fifo_push_o,
  output logic             fifo_pop_o,
  output logic             fifo_flush_o,
  input  logic [CNT_W-1:0] fifo_cnt_i,
  input  logic             fifo_empty_i
);

  pf_state_e        state_q;
  pf_state_e        next_state;

  // Transactions accepted but not yet answered
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] next_cnt;

  // Wrong-path responses still to be dropped
  logic [CNT_W-1:0] flush_cnt_q;
  logic [CNT_W-1:0] next_flush_cnt;

  // Last address handed to the adapter
  addr_t            trans_addr_q;
  addr_t            trans_addr_incr;
  addr_t            aligned_target;

  logic [CNT_W-1:0] fifo_cnt_masked;
  // Sum of buffered and outstanding words, one bit wider against overflow
  logic [CNT_W:0]   occupancy;
  logic             trans_accept;
  logic             flushing;

  ////////////////////////////////
  // Request generation
  ////////////////////////////////

  // Word fetches only
  assign aligned_target  = {branch_i.target[31:2], 2'b00};
  assign trans_addr_incr = {trans_addr_q[31:2], 2'b00} + addr_t'(WORD_BYTES);

  // A branch flushes the FIFO this cycle so its entries free up at once
  assign fifo_cnt_masked = branch_i.taken ? '0 : fifo_cnt_i;
  assign occupancy       = fifo_cnt_masked + cnt_q;

  // Never ask for more than the FIFO can absorb
  assign trans_valid_o = req_i && (occupancy < FIFO_DEPTH);
  assign trans_accept  = trans_valid_o && trans_ready_i;

  assign busy_o = (cnt_q != '0) || trans_valid_o;

  ////////////////////////////////
  // Address FSM
  ////////////////////////////////

  always_comb begin
    next_state   = state_q;
    trans_addr_o = trans_addr_q;
    case (state_q)
      IDLE: begin
        // Branch target wins over sequential prefetch
        if (branch_i.taken) begin
          trans_addr_o = aligned_target;
        end else begin
          trans_addr_o = trans_addr_incr;
        end
        // Target not taken by the adapter yet, replay it
        if (branch_i.taken && !trans_accept) begin
          next_state = BRANCH_WAIT;
        end
      end
      BRANCH_WAIT: begin
        // A newer branch overrides the pending target
        trans_addr_o = branch_i.taken ? aligned_target : trans_addr_q;
        if (trans_accept) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  ////////////////////////////////
  // Fetch and FIFO control
  ////////////////////////////////

  // Old responses are being dropped
  assign flushing = branch_i.taken || (flush_cnt_q != '0);

  // FIFO head or a response falling through
  assign fetch_valid_o = (!fifo_empty_i || resp_valid_i) && !flushing;

  // Buffer a response unless it goes straight to the fetch stage
  assign fifo_push_o  = resp_valid_i && (!fifo_empty_i || !fetch_ready_i) && !flushing;
  assign fifo_pop_o   = !fifo_empty_i && fetch_ready_i;
  assign fifo_flush_o = branch_i.taken;

  ////////////////////////////////
  // Counters
  ////////////////////////////////

  // Up on accept, down on response
  always_comb begin
    case ({trans_accept, resp_valid_i})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;
    endcase
  end

  always_comb begin
    next_flush_cnt = flush_cnt_q;
    if (branch_i.taken) begin
      // Everything in flight belongs to the old path
      next_flush_cnt = cnt_q;
      // A response in this very cycle is already dropped
      if (resp_valid_i && (cnt_q != '0)) begin
        next_flush_cnt = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      next_flush_cnt = flush_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      trans_addr_q <= '0;
    end else begin
      state_q     <= next_state;
      cnt_q       <= next_cnt;
      flush_cnt_q <= next_flush_cnt;
      // Remember the target or the address just accepted
      if (branch_i.taken || trans_accept) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

endmodule

//--- prefetch/prefetch_buffer.sv
// Prefetch buffer top with controller, instruction FIFO and bus adapter
module prefetch_buffer
  import prefetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,

  // Fetch stage
  input  logic     req_i,
  input  branch_t  branch_i,
  input  logic     fetch_ready_i,
  output fetch_t   fetch_o,
  output logic     busy_o,

  // Instruction memory
  output obi_req_t obi_req_o,
  input  obi_rsp_t obi_rsp_i
);

  localparam int unsigned CNT_W = ((FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1) + 1;

  // Controller to adapter
  logic             trans_valid;
  logic             trans_ready;
  addr_t            trans_addr;
  logic             resp_valid;
  instr_t           resp_rdata;

  // Controller to FIFO
  logic             fifo_push;
  logic             fifo_pop;
  logic             fifo_flush;
  logic [CNT_W-1:0] fifo_cnt;
  logic             fifo_empty;
  instr_t           fifo_rdata;
  logic             fetch_valid;

  prefetch_ctrl #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .fetch_ready_i(fetch_ready_i),
    .fetch_valid_o(fetch_valid),
    .busy_o       (busy_o),
    .trans_valid_o(trans_valid),
    .trans_ready_i(trans_ready),
    .trans_addr_o (trans_addr),
    .resp_valid_i (resp_valid),
    .fifo_push_o  (fifo_push),
    .fifo_pop_o   (fifo_pop),
    .fifo_flush_o (fifo_flush),
    .fifo_cnt_i   (fifo_cnt),
    .fifo_empty_i (fifo_empty)
  );

  fetch_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .push_i (fifo_push),
    .pop_i  (fifo_pop),
    .flush_i(fifo_flush),
    .wdata_i(resp_rdata),
    .rdata_o(fifo_rdata),
    .cnt_o  (fifo_cnt),
    .empty_o(fifo_empty)
  );

  instr_obi_adapter u_adapter (
    .clk          (clk),
    .rst_n        (rst_n),
    .trans_valid_i(trans_valid),
    .trans_ready_o(trans_ready),
    .trans_addr_i (trans_addr),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .obi_req_o    (obi_req_o),
    .obi_rsp_i    (obi_rsp_i)
  );

  // Empty FIFO lets the response fall through
  assign fetch_o = fetch_t'{valid: fetch_valid, instr: fifo_empty ? resp_rdata : fifo_rdata};

endmodule

//--- testbench/prefetch_asserts.sv
// Bound checks on bus request stability and fetch output behavior
module prefetch_asserts
  import prefetch_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input branch_t  branch_i,
  input logic     fetch_ready_i,
  input fetch_t   fetch_o,
  input obi_req_t obi_req_o,
  input obi_rsp_t obi_rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Request and address frozen until granted
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o.req && !obi_rsp_i.gnt |=> obi_req_o.req && $stable(obi_req_o.addr))
    else $error("bus request changed before grant");

  // Wrong-path data never reaches the fetch stage
  no_valid_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i.taken |-> !fetch_o.valid)
    else $error("fetch valid during a taken branch");

  // Stalled instruction held until taken or flushed
  fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_o.valid && !fetch_ready_i |=>
      branch_i.taken || (fetch_o.valid && $stable(fetch_o.instr)))
    else $error("stalled fetch output changed");

endmodule

bind prefetch_buffer prefetch_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .branch_i     (branch_i),
  .fetch_ready_i(fetch_ready_i),
  .fetch_o      (fetch_o),
  .obi_req_o    (obi_req_o),
  .obi_rsp_i    (obi_rsp_i)
);

//--- testbench/tb_prefetch.sv
// Prefetch buffer testbench with clock, memory model, stimulus, reference model, scoreboard, report
module tb_prefetch
  import prefetch_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FIFO_DEPTH = 4;
  // Data pattern of the memory mixed into every address bit
  localparam logic [31:0] DATA_KEY   = 32'h5a3c_96e1;

  logic     clk;
  logic     rst_n;
  logic     req_i;
  branch_t  branch_i;
  logic     fetch_ready_i;
  fetch_t   fetch_o;
  logic     busy_o;
  obi_req_t obi_req_o;
  obi_rsp_t obi_rsp_i;

  // Memory model state
  addr_t       resp_addr_q [$];
  int          resp_due_q [$];
  int          cyc;
  int          outstanding;
  int unsigned next_delay;
  logic [15:0] lfsr_q;

  // Bus request hold tracking
  logic        req_pending;
  obi_req_t    held_req;

  // Scoreboard and counters
  addr_t       exp_addr;
  int          deliveries;
  int          checks;
  int          errors;
  logic        ready_random;
  logic        ready_level;

  prefetch_buffer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .fetch_ready_i(fetch_ready_i),
    .fetch_o      (fetch_o),
    .busy_o       (busy_o),
    .obi_req_o    (obi_req_o),
    .obi_rsp_i    (obi_rsp_i)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reference model and random source
  //////////////////////////////

  // Memory content of one word address
  function automatic instr_t expected_instr(input addr_t addr);
    return instr_t'(addr ^ DATA_KEY);
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = (v << 1) | lfsr_q[0];
    end
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_instr(input instr_t got, input instr_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_req(input obi_req_t got, input obi_req_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // Memory model, grant and ready drive
  //////////////////////////////

  always @(negedge clk) begin
    int unsigned r;
    if (!rst_n) begin
      obi_rsp_i = '0;
    end else begin
      // Grant about three times in four
      draw_bits(2, r);
      obi_rsp_i.gnt = (r != 0);
      draw_bits(2, r);
      next_delay = (r % 3) + 1;
      if (ready_random) begin
        draw_bits(1, r);
        fetch_ready_i = r[0];
      end else begin
        fetch_ready_i = ready_level;
      end
      // In-order response once the head is due
      if (resp_addr_q.size() > 0 && resp_due_q[0] <= cyc) begin
        obi_rsp_i.rvalid = 1'b1;
        obi_rsp_i.rdata  = expected_instr(resp_addr_q[0]);
      end else begin
        obi_rsp_i.rvalid = 1'b0;
        obi_rsp_i.rdata  = 32'hdead_beef;
      end
    end
  end

  //////////////////////////////
  // Bus monitor and scoreboard
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      // Ungranted request must not move
      if (req_pending) begin
        check_req(obi_req_o, held_req, "obi_req_o");
      end
      req_pending = obi_req_o.req && !obi_rsp_i.gnt;
      held_req    = obi_req_o;
      if (obi_rsp_i.rvalid) begin
        void'(resp_addr_q.pop_front());
        void'(resp_due_q.pop_front());
        outstanding--;
      end
      if (obi_req_o.req && obi_rsp_i.gnt) begin
        resp_addr_q.push_back(obi_req_o.addr);
        resp_due_q.push_back(cyc + int'(next_delay) - 1);
        outstanding++;
        if (outstanding > FIFO_DEPTH) begin
          errors++;
          $display("error: %0d bus requests outstanding, limit is %0d", outstanding, FIFO_DEPTH);
        end
      end
      // New stream starts at the aligned target
      if (branch_i.taken) begin
        exp_addr = {branch_i.target[31:2], 2'b00};
      end else if (fetch_o.valid && fetch_ready_i) begin
        check_instr(fetch_o.instr, expected_instr(exp_addr), "fetch_o.instr");
        exp_addr = exp_addr + addr_t'(WORD_BYTES);
        deliveries++;
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic start_fetch(input addr_t target);
    @(negedge clk);
    req_i    = 1'b1;
    branch_i = '{taken: 1'b1, target: target};
    @(negedge clk);
    branch_i = '0;
  endtask

  // Mode takes effect at the next falling edge
  task automatic set_ready_mode(input logic random, input logic level);
    @(posedge clk);
    ready_random = random;
    ready_level  = level;
  endtask

  task automatic wait_deliveries(input int n, input int limit);
    int start;
    int waited;
    start  = deliveries;
    waited = 0;
    while (deliveries < start + n && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (deliveries < start + n) begin
      errors++;
      $display("timeout: %0d of %0d deliveries after %0d cycles", deliveries - start, n, limit);
    end
  endtask

  task automatic wait_idle(input int limit);
    int waited;
    waited = 0;
    while ((busy_o || outstanding != 0 || resp_addr_q.size() != 0) && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (busy_o || outstanding != 0) begin
      errors++;
      $display("timeout: prefetch buffer still busy after %0d cycles", limit);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s: %s", name, (errors == err_start) ? "ok" : "errors");
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int err_start;
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = '0;
    fetch_ready_i = 1'b0;
    obi_rsp_i     = '0;
    lfsr_q        = 16'd38;
    cyc           = 0;
    outstanding   = 0;
    next_delay    = 1;
    req_pending   = 1'b0;
    held_req      = '0;
    exp_addr      = '0;
    deliveries    = 0;
    checks        = 0;
    errors        = 0;
    ready_random  = 1'b0;
    ready_level   = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Straight sequential stream
    err_start = errors;
    start_fetch(32'h0000_1000);
    wait_deliveries(20, 400);
    report_test("sequential stream", err_start);

    // Unaligned target
    err_start = errors;
    start_fetch(32'h0000_2002);
    wait_deliveries(8, 200);
    report_test("alignment", err_start);

    // Branches over full FIFO and responses in flight
    err_start = errors;
    for (int i = 0; i < 4; i++) begin
      set_ready_mode(1'b0, 1'b0);
      repeat (3 + i) @(negedge clk);
      start_fetch(32'h0000_3000 + i * 32'h140 + i);
      set_ready_mode(1'b0, 1'b1);
      wait_deliveries(2 + i, 200);
      start_fetch(32'h0000_5000 + i * 32'h80);
      wait_deliveries(3, 200);
    end
    report_test("flush on branch", err_start);

    // Random back-pressure
    err_start = errors;
    set_ready_mode(1'b1, 1'b1);
    start_fetch(32'h0000_4000);
    wait_deliveries(40, 1000);
    report_test("back-pressure", err_start);

    // Drain and stay quiet, the bus address is free while req is low
    err_start = errors;
    set_ready_mode(1'b0, 1'b1);
    @(negedge clk);
    req_i = 1'b0;
    wait_idle(100);
    repeat (10) begin
      @(posedge clk);
      check_flag(obi_req_o.req, 1'b0, "obi_req_o.req");
      check_flag(busy_o, 1'b0, "busy_o");
    end
    report_test("idle", err_start);

    $display("deliveries %0d, checks %0d, errors %0d", deliveries, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
common/prefetch_pkg.sv
source/instr_obi_adapter.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_ctrl.sv
prefetch/prefetch_buffer.sv
testbench/prefetch_asserts.sv
testbench/tb_prefetch.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_prefetch -f tb.f -o sim_prefetch \
  && ./obj_dir/sim_prefetch > sim.log 2>&1 \
  && grep -qx "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
